//--- src/fft_pkg.sv
package fft_pkg;

    // widths at the ports and inside the datapath
    localparam int SAMPLE_W   = 16;
    localparam int WORD_W     = 2 * SAMPLE_W;
    localparam int ACC_W      = 32;
    localparam int FRAC_SHIFT = 8;

    // frame geometry
    localparam int FRAME_LEN = 16;
    localparam int POS_W     = 4;

    // *****************************************************************
    // twiddle table, Q16, entry k is cos and -sin of 2*pi*k/16
    // *****************************************************************
    localparam int TW_SHIFT = 16;

    localparam logic signed [ACC_W-1:0] TW_RE [0:9] = '{
        (1 <<< TW_SHIFT),
        32'sh0000_EC83,
        32'sh0000_B504,
        32'sh0000_61F7,
        32'sh0000_0000,
        32'shFFFF_9E09,
        32'shFFFF_4AFC,
        32'shFFFF_137D,
        -(1 <<< TW_SHIFT),
        32'shFFFF_137D
    };

    localparam logic signed [ACC_W-1:0] TW_IM [0:9] = '{
        32'sh0000_0000,
        32'shFFFF_9E09,
        32'shFFFF_4AFC,
        32'shFFFF_137D,
        -(1 <<< TW_SHIFT),
        32'shFFFF_137D,
        32'shFFFF_4AFC,
        32'shFFFF_9E09,
        32'sh0000_0000,
        32'sh0000_61F7
    };

    // one complex sample, raw or split into real (upper) and imaginary (lower)
    typedef union packed {
        logic [WORD_W-1:0] word;
        struct packed {
            logic signed [SAMPLE_W-1:0] re;
            logic signed [SAMPLE_W-1:0] im;
        } parts;
    } sample_u;

endpackage

//--- src/frame_counter.sv
`timescale 1ns/1ps

module frame_counter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_valid,
    output logic [fft_pkg::POS_W-1:0] o_pos
);
    import fft_pkg::*;

    // position of the sample present on this cycle
    // once started it runs the full frame, then rests at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            o_pos <= '0;
        end else if (o_pos == POS_W'(FRAME_LEN - 1)) begin
            o_pos <= '0;
        end else if (i_valid || (o_pos != '0)) begin
            o_pos <= o_pos + 1'b1;
        end
    end

endmodule

//--- src/twiddle_mult.sv
`timescale 1ns/1ps

module twiddle_mult (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_valid,
    input  logic signed [fft_pkg::SAMPLE_W-1:0] i_re,
    input  logic signed [fft_pkg::SAMPLE_W-1:0] i_im,
    output logic                                o_valid,
    output logic signed [fft_pkg::ACC_W-1:0]    o_re,
    output logic signed [fft_pkg::ACC_W-1:0]    o_im
);
    import fft_pkg::*;

    logic [POS_W-1:0]               pos;
    logic [1:0]                     m;
    logic [1:0]                     grp_rev;
    logic [POS_W-1:0]               tw_exp;
    logic signed [ACC_W-1:0]        tw_re;
    logic signed [ACC_W-1:0]        tw_im;
    logic signed [SAMPLE_W+ACC_W:0] prod_re;
    logic signed [SAMPLE_W+ACC_W:0] prod_im;
    logic signed [SAMPLE_W+ACC_W:0] mul_re;
    logic signed [SAMPLE_W+ACC_W:0] mul_im;
    logic signed [SAMPLE_W+ACC_W:0] rnd_re;
    logic signed [SAMPLE_W+ACC_W:0] rnd_im;
    logic                           mul_valid;

    frame_counter u_cnt (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_valid),
        .o_pos   (pos)
    );

    // *****************************************************************
    // twiddle select, exponent is m times bit-reversed group
    // *****************************************************************
    assign m       = pos[1:0];
    assign grp_rev = {pos[2], pos[3]};
    assign tw_exp  = m * grp_rev;
    assign tw_re   = TW_RE[tw_exp];
    assign tw_im   = TW_IM[tw_exp];

    // (a + jb)(c + jd), product carries 16 fraction bits
    assign prod_re = i_re * tw_re - i_im * tw_im;
    assign prod_im = i_re * tw_im + i_im * tw_re;

    always_ff @(posedge clk) begin
        if (rst) begin
            mul_valid <= 1'b0;
            mul_re    <= '0;
            mul_im    <= '0;
        end else begin
            mul_valid <= i_valid;
            mul_re    <= prod_re;
            mul_im    <= prod_im;
        end
    end

    // round half up down to 8 fraction bits
    assign rnd_re = (mul_re + (1 <<< (FRAC_SHIFT - 1))) >>> FRAC_SHIFT;
    assign rnd_im = (mul_im + (1 <<< (FRAC_SHIFT - 1))) >>> FRAC_SHIFT;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= 1'b0;
            o_re    <= '0;
            o_im    <= '0;
        end else begin
            o_valid <= mul_valid;
            o_re    <= rnd_re[ACC_W-1:0];
            o_im    <= rnd_im[ACC_W-1:0];
        end
    end

endmodule

//--- src/bf2_first.sv
`timescale 1ns/1ps

module bf2_first (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             i_valid,
    input  logic signed [fft_pkg::ACC_W-1:0] i_re,
    input  logic signed [fft_pkg::ACC_W-1:0] i_im,
    output logic                             o_valid,
    output logic signed [fft_pkg::ACC_W-1:0] o_re,
    output logic signed [fft_pkg::ACC_W-1:0] o_im
);
    import fft_pkg::*;

    logic [POS_W-1:0]        pos;
    logic signed [ACC_W-1:0] dl_re [0:1];
    logic signed [ACC_W-1:0] dl_im [0:1];
    logic signed [ACC_W-1:0] sum_re;
    logic signed [ACC_W-1:0] sum_im;
    logic signed [ACC_W-1:0] dif_re;
    logic signed [ACC_W-1:0] dif_im;
    logic signed [ACC_W-1:0] out_re;
    logic signed [ACC_W-1:0] out_im;
    logic [1:0]              vld_dly;

    frame_counter u_cnt (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_valid),
        .o_pos   (pos)
    );

    // butterfly against the sample two back
    assign sum_re = dl_re[1] + i_re;
    assign sum_im = dl_im[1] + i_im;
    assign dif_re = dl_re[1] - i_re;
    assign dif_im = dl_im[1] - i_im;

    // positions 2 and 3 emit the sum, 0 and 1 drain the line
    assign out_re = pos[1] ? sum_re : dl_re[1];
    assign out_im = pos[1] ? sum_im : dl_im[1];

    // *****************************************************************
    // feedback line, shifts every cycle
    // *****************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            dl_re[0] <= '0;
            dl_re[1] <= '0;
            dl_im[0] <= '0;
            dl_im[1] <= '0;
        end else begin
            dl_re[1] <= dl_re[0];
            dl_im[1] <= dl_im[0];
            dl_re[0] <= pos[1] ? dif_re : i_re;
            dl_im[0] <= pos[1] ? dif_im : i_im;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_dly <= '0;
            o_valid <= 1'b0;
            o_re    <= '0;
            o_im    <= '0;
        end else begin
            vld_dly <= {vld_dly[0], i_valid};
            o_valid <= vld_dly[1];
            o_re    <= out_re;
            o_im    <= out_im;
        end
    end

endmodule

//--- src/bf2_second.sv
`timescale 1ns/1ps

module bf2_second (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_valid,
    input  logic signed [fft_pkg::ACC_W-1:0]    i_re,
    input  logic signed [fft_pkg::ACC_W-1:0]    i_im,
    output logic                                o_valid,
    output logic signed [fft_pkg::SAMPLE_W-1:0] o_re,
    output logic signed [fft_pkg::SAMPLE_W-1:0] o_im
);
    import fft_pkg::*;

    logic [POS_W-1:0]        pos;
    logic signed [ACC_W-1:0] in_re;
    logic signed [ACC_W-1:0] in_im;
    logic signed [ACC_W-1:0] dl_re;
    logic signed [ACC_W-1:0] dl_im;
    logic signed [ACC_W-1:0] sum_re;
    logic signed [ACC_W-1:0] sum_im;
    logic signed [ACC_W-1:0] dif_re;
    logic signed [ACC_W-1:0] dif_im;
    logic signed [ACC_W-1:0] pick_re;
    logic signed [ACC_W-1:0] pick_im;
    logic signed [ACC_W-1:0] rnd_re;
    logic signed [ACC_W-1:0] rnd_im;
    logic                    vld_dly;

    frame_counter u_cnt (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_valid),
        .o_pos   (pos)
    );

    // -j on the fourth sample of a group
    always_comb begin
        if (pos[1:0] == 2'b11) begin
            in_re = i_im;
            in_im = -i_re;
        end else begin
            in_re = i_re;
            in_im = i_im;
        end
    end

    assign sum_re  = dl_re + in_re;
    assign sum_im  = dl_im + in_im;
    assign dif_re  = dl_re - in_re;
    assign dif_im  = dl_im - in_im;
    assign pick_re = pos[0] ? sum_re : dl_re;
    assign pick_im = pos[0] ? sum_im : dl_im;

    // drop the internal fraction bits, round half up
    assign rnd_re = (pick_re + (1 <<< (FRAC_SHIFT - 1))) >>> FRAC_SHIFT;
    assign rnd_im = (pick_im + (1 <<< (FRAC_SHIFT - 1))) >>> FRAC_SHIFT;

    always_ff @(posedge clk) begin
        if (rst) begin
            dl_re   <= '0;
            dl_im   <= '0;
            vld_dly <= 1'b0;
            o_valid <= 1'b0;
            o_re    <= '0;
            o_im    <= '0;
        end else begin
            dl_re   <= pos[0] ? dif_re : in_re;
            dl_im   <= pos[0] ? dif_im : in_im;
            vld_dly <= i_valid;
            o_valid <= vld_dly;
            o_re    <= rnd_re[SAMPLE_W-1:0];
            o_im    <= rnd_im[SAMPLE_W-1:0];
        end
    end

endmodule

//--- src/fft_tail_top.sv
`timescale 1ns/1ps

module fft_tail_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_valid,
    input  logic [fft_pkg::WORD_W-1:0] i_data,
    output logic                       o_valid,
    output logic [fft_pkg::WORD_W-1:0] o_data
);
    import fft_pkg::*;

    sample_u                    in_s;
    sample_u                    out_s;
    logic                       tw_valid;
    logic signed [ACC_W-1:0]    tw_re;
    logic signed [ACC_W-1:0]    tw_im;
    logic                       b1_valid;
    logic signed [ACC_W-1:0]    b1_re;
    logic signed [ACC_W-1:0]    b1_im;
    logic signed [SAMPLE_W-1:0] b2_re;
    logic signed [SAMPLE_W-1:0] b2_im;

    assign in_s.word = i_data;

    // *****************************************************************
    // twiddle, then distance-two and distance-one butterflies
    // *****************************************************************
    twiddle_mult u_twiddle (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_valid),
        .i_re    (in_s.parts.re),
        .i_im    (in_s.parts.im),
        .o_valid (tw_valid),
        .o_re    (tw_re),
        .o_im    (tw_im)
    );

    bf2_first u_bf1 (
        .clk     (clk),
        .rst     (rst),
        .i_valid (tw_valid),
        .i_re    (tw_re),
        .i_im    (tw_im),
        .o_valid (b1_valid),
        .o_re    (b1_re),
        .o_im    (b1_im)
    );

    bf2_second u_bf2 (
        .clk     (clk),
        .rst     (rst),
        .i_valid (b1_valid),
        .i_re    (b1_re),
        .i_im    (b1_im),
        .o_valid (o_valid),
        .o_re    (b2_re),
        .o_im    (b2_im)
    );

    assign out_s.parts.re = b2_re;
    assign out_s.parts.im = b2_im;
    assign o_data         = out_s.word;

endmodule

//--- test/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic o_clk
);

    // free running, starts low
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

endmodule

//--- test/fft_tail_checker.sv
`timescale 1ns/1ps

module fft_tail_checker (
    input logic                       clk,
    input logic                       rst,
    input logic                       i_valid,
    input logic                       o_valid,
    input logic [fft_pkg::WORD_W-1:0] o_data
);

    localparam int LATENCY = 7;

    int         fail_count = 0;
    logic [3:0] warm;

    // cycles since reset, stops once the valid history covers the pipeline
    always_ff @(posedge clk) begin
        if (rst) begin
            warm <= '0;
        end else if (warm != 4'(LATENCY)) begin
            warm <= warm + 1'b1;
        end
    end

    // **********************************************************************
    // top-level timing
    // **********************************************************************
    a_reset_quiet: assert property (@(posedge clk) (rst || $past(rst)) |=> !o_valid)
        else begin
            $error("o_valid high during or right after reset");
            fail_count++;
        end

    a_latency: assert property (@(posedge clk) disable iff (rst)
        (warm == 4'(LATENCY)) |-> (o_valid == $past(i_valid, LATENCY)))
        else begin
            $error("o_valid is not i_valid delayed by %0d cycles", LATENCY);
            fail_count++;
        end

    a_data_known: assert property (@(posedge clk) disable iff (rst)
        o_valid |-> !$isunknown(o_data))
        else begin
            $error("o_data has unknown bits while o_valid is high");
            fail_count++;
        end

endmodule

bind fft_tail_top fft_tail_checker u_checker (
    .clk     (clk),
    .rst     (rst),
    .i_valid (i_valid),
    .o_valid (o_valid),
    .o_data  (o_data)
);

//--- test/tb_fft_tail.sv
`timescale 1ns/1ps

module tb_fft_tail;
    import fft_pkg::*;

    localparam int LATENCY    = 7;
    localparam int WAIT_LIMIT = 100;

    logic              clk;
    logic              rst;
    logic              i_valid;
    logic [WORD_W-1:0] i_data;
    logic              o_valid;
    logic [WORD_W-1:0] o_data;

    integer  seed;
    int      cycle = 0;
    int      checks = 0;
    int      value_errors = 0;
    int      count_errors = 0;
    int      timeouts = 0;
    int      assert_fails;
    sample_u stim [FRAME_LEN];
    sample_u sent_q [$];
    sample_u out_q [$];
    int      in_cyc [$];
    int      out_cyc [$];

    clk_gen u_clk (.o_clk(clk));

    fft_tail_top uut (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_valid),
        .i_data  (i_data),
        .o_valid (o_valid),
        .o_data  (o_data)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!rst && o_valid) begin
            out_q.push_back(sample_u'(o_data));
            out_cyc.push_back(cycle);
        end
    end

    // **********************************************************************
    // compare tasks
    // **********************************************************************
    task automatic check_sample(input string name, input sample_u exp_s, input sample_u act_s);
        checks++;
        if (act_s.word !== exp_s.word) begin
            value_errors++;
            $display("** Error: %s expected 0x%08h, got 0x%08h", name, exp_s.word,
                     act_s.word);
        end
    endtask

    task automatic check_count(input string name, input int exp_n, input int act_n);
        checks++;
        if (act_n != exp_n) begin
            count_errors++;
            $display("** Error: %s expected 0x%0h, got 0x%0h", name, exp_n, act_n);
        end
    endtask

    task automatic check_latency(input string name, input int exp_n, input int act_n);
        checks++;
        if (act_n != exp_n) begin
            count_errors++;
            $display("** Error: %s latency expected 0x%0h, got 0x%0h", name, exp_n, act_n);
        end
    endtask

    // **********************************************************************
    // reference model
    // **********************************************************************
    function automatic longint round_half_up(input longint v);
        return (v + (longint'(1) <<< (FRAC_SHIFT - 1))) >>> FRAC_SHIFT;
    endfunction

    task automatic model_frame(input sample_u f [FRAME_LEN], output sample_u e [FRAME_LEN]);
        longint xr [FRAME_LEN];
        longint xi [FRAME_LEN];
        longint yr [4];
        longint yi [4];
        int     g;
        int     ex;
        int     b;
        for (int n = 0; n < FRAME_LEN; n++) begin
            g  = n / 4;
            // exponent is m times the bit-reversed group
            ex = (n % 4) * (((g & 1) << 1) | (g >> 1));
            xr[n] = round_half_up(longint'(f[n].parts.re) * TW_RE[ex]
                                  - longint'(f[n].parts.im) * TW_IM[ex]);
            xi[n] = round_half_up(longint'(f[n].parts.re) * TW_IM[ex]
                                  + longint'(f[n].parts.im) * TW_RE[ex]);
        end
        for (int grp = 0; grp < FRAME_LEN / 4; grp++) begin
            b     = 4 * grp;
            yr[0] = xr[b] + xr[b+1] + xr[b+2] + xr[b+3];
            yi[0] = xi[b] + xi[b+1] + xi[b+2] + xi[b+3];
            yr[1] = xr[b] - xr[b+1] + xr[b+2] - xr[b+3];
            yi[1] = xi[b] - xi[b+1] + xi[b+2] - xi[b+3];
            yr[2] = (xr[b] - xr[b+2]) + (xi[b+1] - xi[b+3]);
            yi[2] = (xi[b] - xi[b+2]) - (xr[b+1] - xr[b+3]);
            yr[3] = (xr[b] - xr[b+2]) - (xi[b+1] - xi[b+3]);
            yi[3] = (xi[b] - xi[b+2]) + (xr[b+1] - xr[b+3]);
            for (int k = 0; k < 4; k++) begin
                e[b+k].parts.re = SAMPLE_W'(round_half_up(yr[k]));
                e[b+k].parts.im = SAMPLE_W'(round_half_up(yi[k]));
            end
        end
    endtask

    // **********************************************************************
    // stimulus and collection
    // **********************************************************************
    task automatic zero_frame(output sample_u f [FRAME_LEN]);
        for (int k = 0; k < FRAME_LEN; k++) begin
            f[k].word = '0;
        end
    endtask

    task automatic fill_random(output sample_u f [FRAME_LEN]);
        for (int k = 0; k < FRAME_LEN; k++) begin
            f[k].parts.re = SAMPLE_W'($random(seed) % 2048);
            f[k].parts.im = SAMPLE_W'($random(seed) % 2048);
        end
    endtask

    task automatic clear_queues();
        sent_q.delete();
        out_q.delete();
        in_cyc.delete();
        out_cyc.delete();
    endtask

    // leaves i_valid high so the next frame can follow directly
    task automatic drive_frame(input sample_u f [FRAME_LEN]);
        for (int k = 0; k < FRAME_LEN; k++) begin
            @(negedge clk);
            i_valid = 1'b1;
            i_data  = f[k].word;
            sent_q.push_back(f[k]);
            in_cyc.push_back(cycle);
        end
    endtask

    task automatic go_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            i_valid = 1'b0;
            i_data  = '0;
        end
    endtask

    task automatic collect(input int n);
        int waited;
        waited = 0;
        while (out_q.size() < n && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (out_q.size() < n) begin
            timeouts++;
            $display("timeout: only %0d of %0d output strobes arrived", out_q.size(), n);
        end
        // a few more cycles so that any extra strobe would show up
        repeat (LATENCY + 3) @(posedge clk);
        check_count("o_valid strobes", n, out_q.size());
    endtask

    task automatic check_frames();
        sample_u f [FRAME_LEN];
        sample_u e [FRAME_LEN];
        int      idx;
        for (int fr = 0; fr < sent_q.size() / FRAME_LEN; fr++) begin
            for (int k = 0; k < FRAME_LEN; k++) begin
                f[k] = sent_q[fr * FRAME_LEN + k];
            end
            model_frame(f, e);
            for (int k = 0; k < FRAME_LEN; k++) begin
                idx = fr * FRAME_LEN + k;
                if (idx < out_q.size()) begin
                    check_sample($sformatf("o_data frame %0d sample %0d", fr, k), e[k],
                                 out_q[idx]);
                end
            end
        end
    endtask

    // **********************************************************************
    // directed tests
    // **********************************************************************
    task automatic reset_idle_test();
        clear_queues();
        repeat (50) @(posedge clk);
        check_count("o_valid strobes with no input", 0, out_q.size());
    endtask

    task automatic impulse_test();
        sample_u exp_s;
        clear_queues();
        zero_frame(stim);
        stim[0].parts.re = 16'sh0100;
        drive_frame(stim);
        go_idle(1);
        collect(FRAME_LEN);
        for (int k = 0; k < FRAME_LEN && k < out_q.size(); k++) begin
            exp_s.word = (k < 4) ? 32'h0100_0000 : 32'h0;
            check_sample($sformatf("o_data impulse sample %0d", k), exp_s, out_q[k]);
        end
    endtask

    task automatic twiddle_test();
        clear_queues();
        zero_frame(stim);
        stim[5].parts.re  = 16'sh0123;
        stim[5].parts.im  = -16'sh0045;
        stim[9].parts.re  = -16'sh0200;
        stim[9].parts.im  = 16'sh0155;
        stim[11].parts.re = 16'sh0301;
        stim[11].parts.im = 16'sh00f7;
        stim[13].parts.re = -16'sh0099;
        stim[13].parts.im = -16'sh0310;
        stim[15].parts.re = 16'sh0444;
        stim[15].parts.im = -16'sh0123;
        drive_frame(stim);
        go_idle(1);
        collect(FRAME_LEN);
        check_frames();
    endtask

    task automatic random_test();
        clear_queues();
        for (int fr = 0; fr < 3; fr++) begin
            fill_random(stim);
            drive_frame(stim);
        end
        go_idle(1);
        collect(3 * FRAME_LEN);
        check_frames();
    endtask

    task automatic gap_test();
        clear_queues();
        fill_random(stim);
        drive_frame(stim);
        go_idle(10);
        fill_random(stim);
        drive_frame(stim);
        go_idle(1);
        collect(2 * FRAME_LEN);
        for (int k = 0; k < out_cyc.size() && k < in_cyc.size(); k++) begin
            check_latency($sformatf("o_valid strobe %0d", k), LATENCY, out_cyc[k] - in_cyc[k]);
        end
        check_frames();
    endtask

    task automatic rounding_test();
        clear_queues();
        for (int k = 0; k < FRAME_LEN; k++) begin
            stim[k].parts.re = SAMPLE_W'(-(1 + 2 * ((k * 29) % 500)));
            stim[k].parts.im = SAMPLE_W'(-(3 + 2 * ((k * 41) % 700)));
        end
        // real product at position 5 sits exactly on a half step
        stim[5].parts.re = -16'sd113;
        stim[5].parts.im = -16'sd111;
        drive_frame(stim);
        go_idle(1);
        collect(FRAME_LEN);
        check_frames();
    endtask

    initial begin
        seed    = 32'h9a8b2d57;
        rst     = 1'b1;
        i_valid = 1'b0;
        i_data  = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_idle_test();
        impulse_test();
        twiddle_test();
        random_test();
        gap_test();
        rounding_test();

        assert_fails = uut.u_checker.fail_count;
        $display("checks %0d, value errors %0d, count errors %0d, timeouts %0d, assertion fails %0d",
                 checks, value_errors, count_errors, timeouts, assert_fails);
        if (value_errors + count_errors + timeouts + assert_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- project.f
src/fft_pkg.sv
src/frame_counter.sv
src/twiddle_mult.sv
src/bf2_first.sv
src/bf2_second.sv
src/fft_tail_top.sv
test/clk_gen.sv
test/fft_tail_checker.sv
test/tb_fft_tail.sv

//--- Bender.yml
package:
  name: fft_tail

sources:
  - files:
      - src/fft_pkg.sv
      - src/frame_counter.sv
      - src/twiddle_mult.sv
      - src/bf2_first.sv
      - src/bf2_second.sv
      - src/fft_tail_top.sv
  - target: test
    files:
      - test/clk_gen.sv
      - test/fft_tail_checker.sv
      - test/tb_fft_tail.sv
